// ==== compile.f ====
+incdir+include
verilog/dma_cfg_pkg.sv
verilog/dma_cfg_apb_decode.sv
verilog/dma_cfg_regfile.sv
verilog/dma_cfg_irq.sv
verilog/dma_cfg_readback.sv
verilog/dma_cfg_top.sv
verification/dma_cfg_tb.sv

// ==== verification/dma_cfg_tb.sv ====
`default_nettype none

`include "dma_cfg_consts.svh"

module dma_cfg_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                           pclk;
  logic                           preset_n;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [7:0]                     paddr;
  logic [31:0]                    pwdata;
  logic [9:0]                     events;
  logic [31:0]                    prdata;
  dma_cfg_pkg::dma_cfg_t          o_cfg;
  dma_cfg_pkg::axi_ctrl_fields_t  o_axi;
  logic                           npu_start;
  logic                           npu_stop;
  logic                           init_inst;
  logic                           sys_reset_n;
  logic                           interrupt;

  logic [31:0] lfsr_state = 32'h658699f5;
  logic        rst_in_access;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;

  dma_cfg_top UUT (
    .pclk          (pclk),
    .preset_n      (preset_n),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_paddr       (paddr),
    .i_pwdata      (pwdata),
    .o_prdata      (prdata),
    .i_events      (events),
    .o_cfg         (o_cfg),
    .o_axi         (o_axi),
    .o_npu_start   (npu_start),
    .o_npu_stop    (npu_stop),
    .o_init_inst   (init_inst),
    .o_sys_reset_n (sys_reset_n),
    .o_interrupt   (interrupt)
  );

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) w = {w[30:0], lfsr_bit()};
    return w;
  endfunction

  function automatic logic [7:0] slot_addr(int idx);
    return {1'b0, idx[4:0], 2'b00};
  endfunction

  function automatic logic probe_out(int sel);
    case (sel)
      0:       return npu_start;
      1:       return npu_stop;
      2:       return init_inst;
      default: return interrupt;
    endcase
  endfunction

  task automatic check_eq(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_write(int idx, logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= slot_addr(idx);
    pwdata  <= data;
    @(posedge pclk);
    penable <= 1'b1;
    // soft reset is only visible inside the access phase
    @(negedge pclk);
    rst_in_access = sys_reset_n;
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(int idx, output logic [31:0] data);
    @(posedge pclk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= slot_addr(idx);
    @(posedge pclk);
    penable <= 1'b1;
    @(negedge pclk);
    data = prdata;
    @(posedge pclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // counts falling edges until the output is high
  task automatic wait_high(int sel, string name, int limit, output int cycles);
    cycles = 0;
    do begin
      @(negedge pclk);
      cycles++;
    end while (!probe_out(sel) && cycles < limit);
    checks++;
    assert (probe_out(sel)) else begin
      $display("%s never went high within %0d cycles at %0t ns", name, limit, $time);
      errors++;
    end
  endtask

  task automatic end_test(string name, int base);
    tests++;
    if (errors == base) $display("test %s: ok", name);
    else $display("test %s: %0d error(s)", name, errors - base);
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic reset_values();
    int          base;
    logic [31:0] d;
    base = errors;
    apb_read(`DMA_CFG_IDX_IMR, d);
    check_eq("imr", d, 32'h0000_07ff);
    apb_read(`DMA_CFG_IDX_AXI_CTRL, d);
    check_eq("axi_ctrl", d, 32'h048c_0123);
    for (int s = 4; s <= 11; s++) begin
      apb_read(s, d);
      check_eq($sformatf("slot %0d", s), d, 32'h0);
    end
    @(negedge pclk);
    check_eq("o_interrupt", interrupt, 1'b0);
    check_eq("o_sys_reset_n", sys_reset_n, 1'b1);
    end_test("reset_values", base);
  endtask

  task automatic register_round_trip();
    int          base;
    int          slots[$];
    logic [31:0] w [0:19];
    logic [31:0] d;
    logic [31:0] a;
    base = errors;
    slots = {4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 18};
    foreach (slots[i]) begin
      w[slots[i]] = rand_word();
      apb_write(slots[i], w[slots[i]]);
    end
    // zone enable is four bits wide
    w[12] = {28'h0, w[12][3:0]};
    foreach (slots[i]) begin
      apb_read(slots[i], d);
      check_eq($sformatf("slot %0d", slots[i]), d, w[slots[i]]);
    end
    for (int z = 0; z < 4; z++) begin
      check_eq($sformatf("o_cfg.zone[%0d].base", z), o_cfg.zone[z].base, w[4 + 2 * z]);
      check_eq($sformatf("o_cfg.zone[%0d].size", z), o_cfg.zone[z].size, w[5 + 2 * z]);
    end
    check_eq("o_cfg.zone_en", o_cfg.zone_en, w[12]);
    check_eq("o_cfg.src", o_cfg.src, w[13]);
    check_eq("o_cfg.dst", o_cfg.dst, w[14]);
    check_eq("o_cfg.depth", o_cfg.depth, w[15]);
    a = w[18];
    check_eq("o_axi.awid", o_axi.awid, a[31:28]);
    check_eq("o_axi.awburst", o_axi.awburst, a[27:26]);
    check_eq("o_axi.awlock", o_axi.awlock, a[25]);
    check_eq("o_axi.awprot", o_axi.awprot, a[24:22]);
    check_eq("o_axi.awcache", o_axi.awcache, a[21:18]);
    check_eq("o_axi.wid", o_axi.wid, a[17:14]);
    check_eq("o_axi.arid", o_axi.arid, a[13:10]);
    check_eq("o_axi.arburst", o_axi.arburst, a[9:8]);
    check_eq("o_axi.arlock", o_axi.arlock, a[7]);
    check_eq("o_axi.arprot", o_axi.arprot, a[6:4]);
    check_eq("o_axi.arcache", o_axi.arcache, a[3:0]);
    // unmapped slots ignore writes
    slots = {16, 17, 19};
    foreach (slots[i]) begin
      apb_write(slots[i], rand_word());
      apb_read(slots[i], d);
      check_eq($sformatf("slot %0d", slots[i]), d, 32'h0);
    end
    end_test("register_round_trip", base);
  endtask

  task automatic command_pulses();
    int          base;
    int          n;
    logic [31:0] d;
    base = errors;
    apb_write(`DMA_CFG_IDX_CTRL, 32'h1);
    check_eq("o_sys_reset_n in access", rst_in_access, 1'b1);
    wait_high(0, "o_npu_start", 4, n);
    check_eq("o_npu_start delay", n, 1);
    @(negedge pclk);
    check_eq("o_npu_start", npu_start, 1'b0);
    apb_read(`DMA_CFG_IDX_CTRL, d);
    check_eq("ctrl[2:0]", d[2:0], 3'b000);
    apb_write(`DMA_CFG_IDX_CTRL, 32'h2);
    wait_high(1, "o_npu_stop", 4, n);
    check_eq("o_npu_stop delay", n, 1);
    @(negedge pclk);
    check_eq("o_npu_stop", npu_stop, 1'b0);
    apb_read(`DMA_CFG_IDX_CTRL, d);
    check_eq("ctrl[2:0]", d[2:0], 3'b000);
    apb_write(`DMA_CFG_IDX_CTRL, 32'h8);
    check_eq("o_sys_reset_n in access", rst_in_access, 1'b0);
    @(negedge pclk);
    check_eq("o_sys_reset_n", sys_reset_n, 1'b1);
    end_test("command_pulses", base);
  endtask

  task automatic init_depth_check();
    int          base;
    int          n;
    logic        seen;
    logic [31:0] d;
    base = errors;
    apb_write(`DMA_CFG_IDX_DEPTH, 32'h0000_0fff);
    apb_write(`DMA_CFG_IDX_CTRL, 32'h4);
    wait_high(2, "o_init_inst", 4, n);
    check_eq("o_init_inst delay", n, 1);
    @(negedge pclk);
    check_eq("o_init_inst", init_inst, 1'b0);
    // one past the limit
    apb_write(`DMA_CFG_IDX_DEPTH, 32'h0000_1000);
    apb_write(`DMA_CFG_IDX_CTRL, 32'h4);
    seen = 1'b0;
    repeat (4) begin
      @(negedge pclk);
      seen = seen | init_inst;
    end
    check_eq("o_init_inst", seen, 1'b0);
    apb_read(`DMA_CFG_IDX_IRR, d);
    check_eq("irr", d, 32'h0000_0400);
    apb_write(`DMA_CFG_IDX_ISR, 32'h0000_0400);
    apb_read(`DMA_CFG_IDX_IRR, d);
    check_eq("irr", d, 32'h0);
    end_test("init_depth_check", base);
  endtask

  task automatic interrupt_flow();
    int          base;
    int          n;
    int          e;
    logic [9:0]  ev;
    logic [31:0] d;
    base = errors;
    e = rand_word() % 10;
    ev = 10'd1 << e;
    apb_write(`DMA_CFG_IDX_IMR, 32'h0);
    @(posedge pclk);
    events <= ev;
    wait_high(3, "o_interrupt", 8, n);
    apb_read(`DMA_CFG_IDX_IRR, d);
    check_eq("irr", d, {22'h0, ev});
    apb_read(`DMA_CFG_IDX_ISR, d);
    check_eq("isr", d, {22'h0, ev});
    // event still high, no new edge
    apb_write(`DMA_CFG_IDX_ISR, {22'h0, ev});
    @(negedge pclk);
    check_eq("o_interrupt", interrupt, 1'b0);
    apb_read(`DMA_CFG_IDX_IRR, d);
    check_eq("irr", d, 32'h0);
    @(posedge pclk);
    events <= '0;
    @(posedge pclk);
    events <= ev;
    wait_high(3, "o_interrupt", 8, n);
    apb_write(`DMA_CFG_IDX_IMR, {22'h0, ev});
    @(negedge pclk);
    check_eq("o_interrupt", interrupt, 1'b0);
    apb_read(`DMA_CFG_IDX_IRR, d);
    check_eq("irr", d, {22'h0, ev});
    apb_read(`DMA_CFG_IDX_ISR, d);
    check_eq("isr", d, 32'h0);
    apb_write(`DMA_CFG_IDX_ISR, {22'h0, ev});
    apb_read(`DMA_CFG_IDX_IRR, d);
    check_eq("irr", d, 32'h0);
    @(posedge pclk);
    events <= '0;
    end_test("interrupt_flow", base);
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    preset_n = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    events   = '0;
    repeat (4) @(posedge pclk);
    preset_n <= 1'b1;
    reset_values();
    register_round_trip();
    command_pulses();
    init_depth_check();
    interrupt_flow();
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // overall limit on the run
  initial begin
    #100us;
    $display("run did not finish within the time limit");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/dma_cfg_top.sv ====
`default_nettype none

`include "dma_cfg_consts.svh"

module dma_cfg_top (
  input  wire                              pclk,
  input  wire                              preset_n,
  input  wire                              i_psel,
  input  wire                              i_penable,
  input  wire                              i_pwrite,
  input  wire [7:0]                        i_paddr,
  input  wire [`DMA_CFG_DATA_W-1:0]        i_pwdata,
  output logic [`DMA_CFG_DATA_W-1:0]       o_prdata,
  input  wire [`DMA_CFG_IRQ_W-2:0]         i_events,
  output dma_cfg_pkg::dma_cfg_t            o_cfg,
  output dma_cfg_pkg::axi_ctrl_fields_t    o_axi,
  output logic                             o_npu_start,
  output logic                             o_npu_stop,
  output logic                             o_init_inst,
  output logic                             o_sys_reset_n,
  output logic                             o_interrupt
);

  dma_cfg_pkg::reg_wr_t      wr;
  logic [`DMA_CFG_IDX_W-1:0] rd_idx;
  dma_cfg_pkg::dma_cfg_t     cfg;
  dma_cfg_pkg::axi_ctrl_u    axi;
  logic [5:0]                ctrl;
  dma_cfg_pkg::dma_cmd_t     cmd;
  logic                      init_fail;
  dma_cfg_pkg::irq_vec_t     imr;
  dma_cfg_pkg::irq_vec_t     irr;
  dma_cfg_pkg::irq_vec_t     isr;

  // ----------------------------------------------------------------------
  // decode, execute, read back
  // ----------------------------------------------------------------------
  dma_cfg_apb_decode u_decode (
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_wr      (wr),
    .o_rd_idx  (rd_idx)
  );

  dma_cfg_regfile u_regfile (
    .pclk          (pclk),
    .preset_n      (preset_n),
    .i_wr          (wr),
    .o_cfg         (cfg),
    .o_axi         (axi),
    .o_ctrl        (ctrl),
    .o_cmd         (cmd),
    .o_init_fail   (init_fail),
    .o_sys_reset_n (o_sys_reset_n)
  );

  dma_cfg_irq u_irq (
    .pclk        (pclk),
    .preset_n    (preset_n),
    .i_wr        (wr),
    .i_events    (i_events),
    .i_init_fail (init_fail),
    .o_imr       (imr),
    .o_irr       (irr),
    .o_isr       (isr),
    .o_interrupt (o_interrupt)
  );

  dma_cfg_readback u_readback (
    .i_rd_idx (rd_idx),
    .i_cfg    (cfg),
    .i_axi    (axi),
    .i_ctrl   (ctrl),
    .i_imr    (imr),
    .i_irr    (irr),
    .i_isr    (isr),
    .o_prdata (o_prdata)
  );

  // AXI master takes the field view of the same word
  assign o_cfg       = cfg;
  assign o_axi       = axi.fields;
  assign o_npu_start = cmd.npu_start;
  assign o_npu_stop  = cmd.npu_stop;
  assign o_init_inst = cmd.init_inst;

endmodule

`default_nettype wire

// ==== verilog/dma_cfg_readback.sv ====
`default_nettype none

`include "dma_cfg_consts.svh"

module dma_cfg_readback (
  input  wire [`DMA_CFG_IDX_W-1:0]         i_rd_idx,
  input  wire dma_cfg_pkg::dma_cfg_t       i_cfg,
  input  wire dma_cfg_pkg::axi_ctrl_u      i_axi,
  input  wire [5:0]                        i_ctrl,
  input  wire dma_cfg_pkg::irq_vec_t       i_imr,
  input  wire dma_cfg_pkg::irq_vec_t       i_irr,
  input  wire dma_cfg_pkg::irq_vec_t       i_isr,
  output logic [`DMA_CFG_DATA_W-1:0]       o_prdata
);

  // narrow registers zero extended, unmapped slots read zero
  always_comb begin
    o_prdata = '0;
    case (i_rd_idx)
      `DMA_CFG_IDX_CTRL:       o_prdata[5:0] = i_ctrl;
      `DMA_CFG_IDX_IMR:        o_prdata[`DMA_CFG_IRQ_W-1:0] = i_imr;
      `DMA_CFG_IDX_IRR:        o_prdata[`DMA_CFG_IRQ_W-1:0] = i_irr;
      `DMA_CFG_IDX_ISR:        o_prdata[`DMA_CFG_IRQ_W-1:0] = i_isr;
      `DMA_CFG_IDX_ZONE1_ADDR: o_prdata = i_cfg.zone[0].base;
      `DMA_CFG_IDX_ZONE1_SIZE: o_prdata = i_cfg.zone[0].size;
      `DMA_CFG_IDX_ZONE2_ADDR: o_prdata = i_cfg.zone[1].base;
      `DMA_CFG_IDX_ZONE2_SIZE: o_prdata = i_cfg.zone[1].size;
      `DMA_CFG_IDX_ZONE3_ADDR: o_prdata = i_cfg.zone[2].base;
      `DMA_CFG_IDX_ZONE3_SIZE: o_prdata = i_cfg.zone[2].size;
      `DMA_CFG_IDX_ZONE4_ADDR: o_prdata = i_cfg.zone[3].base;
      `DMA_CFG_IDX_ZONE4_SIZE: o_prdata = i_cfg.zone[3].size;
      `DMA_CFG_IDX_ZONE_EN:    o_prdata[3:0] = i_cfg.zone_en;
      `DMA_CFG_IDX_SRC:        o_prdata = i_cfg.src;
      `DMA_CFG_IDX_DST:        o_prdata = i_cfg.dst;
      `DMA_CFG_IDX_DEPTH:      o_prdata = i_cfg.depth;
      // whole word, as written
      `DMA_CFG_IDX_AXI_CTRL:   o_prdata = i_axi.raw;
      default:                 o_prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/dma_cfg_irq.sv ====
`default_nettype none

`include "dma_cfg_consts.svh"

module dma_cfg_irq (
  input  wire                              pclk,
  input  wire                              preset_n,
  input  wire dma_cfg_pkg::reg_wr_t        i_wr,
  input  wire [`DMA_CFG_IRQ_W-2:0]         i_events,
  input  wire                              i_init_fail,
  output dma_cfg_pkg::irq_vec_t            o_imr,
  output dma_cfg_pkg::irq_vec_t            o_irr,
  output dma_cfg_pkg::irq_vec_t            o_isr,
  output logic                             o_interrupt
);

  dma_cfg_pkg::irq_vec_t cause;
  dma_cfg_pkg::irq_vec_t cause_q;
  dma_cfg_pkg::irq_vec_t rise;
  dma_cfg_pkg::irq_vec_t clr;
  dma_cfg_pkg::irq_vec_t imr_q;
  dma_cfg_pkg::irq_vec_t irr_q;

  always_comb begin
    cause[`DMA_CFG_IRQ_INIT_FAIL]     = i_init_fail;
    cause[`DMA_CFG_IRQ_INIT_FAIL-1:0] = i_events;
  end

  // rising edge of each cause
  assign rise = cause & ~cause_q;

  // write one to clear
  assign clr = (i_wr.en && (i_wr.idx == `DMA_CFG_IDX_ISR)) ?
               i_wr.data[`DMA_CFG_IRQ_W-1:0] : '0;

  // ----------------------------------------------------------------------
  // raw and mask registers
  // ----------------------------------------------------------------------
  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      cause_q <= '0;
      irr_q   <= '0;
      imr_q   <= `DMA_CFG_IMR_RST;
    end else begin
      cause_q <= cause;
      // a new edge beats a clear on the same bit
      irr_q   <= rise | (irr_q & ~clr);
      if (i_wr.en && (i_wr.idx == `DMA_CFG_IDX_IMR)) begin
        imr_q <= i_wr.data[`DMA_CFG_IRQ_W-1:0];
      end
    end
  end

  assign o_imr       = imr_q;
  assign o_irr       = irr_q;
  assign o_isr       = irr_q & ~imr_q;
  assign o_interrupt = |o_isr;

  a_irq_has_source: assert property (
    @(posedge pclk) disable iff (!preset_n)
    o_interrupt |-> (o_isr != '0))
    else $error("dma_cfg_irq: interrupt without a pending cause");

endmodule

`default_nettype wire

// ==== verilog/dma_cfg_regfile.sv ====
`default_nettype none

`include "dma_cfg_consts.svh"

module dma_cfg_regfile (
  input  wire                              pclk,
  input  wire                              preset_n,
  input  wire dma_cfg_pkg::reg_wr_t        i_wr,
  output dma_cfg_pkg::dma_cfg_t            o_cfg,
  output dma_cfg_pkg::axi_ctrl_u           o_axi,
  output logic [5:0]                       o_ctrl,
  output dma_cfg_pkg::dma_cmd_t            o_cmd,
  output logic                             o_init_fail,
  output logic                             o_sys_reset_n
);

  dma_cfg_pkg::dma_cfg_t  cfg_q;
  dma_cfg_pkg::axi_ctrl_u axi_q;
  logic [5:0]             ctrl_q;
  logic                   ctrl_wr;
  logic                   depth_ok;

  assign ctrl_wr = i_wr.en && (i_wr.idx == `DMA_CFG_IDX_CTRL);

  // ----------------------------------------------------------------------
  // control register
  // ----------------------------------------------------------------------
  // bits 2..0 are commands and drop back to zero after one cycle
  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      ctrl_q <= '0;
    end else if (ctrl_wr) begin
      ctrl_q <= i_wr.data[5:0];
    end else begin
      ctrl_q[2:0] <= 3'b000;
    end
  end

  // ----------------------------------------------------------------------
  // configuration registers
  // ----------------------------------------------------------------------
  always_ff @(posedge pclk or negedge preset_n) begin
    if (!preset_n) begin
      cfg_q     <= '0;
      axi_q.raw <= `DMA_CFG_AXI_CTRL_RST;
    end else if (i_wr.en) begin
      case (i_wr.idx)
        `DMA_CFG_IDX_ZONE1_ADDR: cfg_q.zone[0].base <= i_wr.data;
        `DMA_CFG_IDX_ZONE1_SIZE: cfg_q.zone[0].size <= i_wr.data;
        `DMA_CFG_IDX_ZONE2_ADDR: cfg_q.zone[1].base <= i_wr.data;
        `DMA_CFG_IDX_ZONE2_SIZE: cfg_q.zone[1].size <= i_wr.data;
        `DMA_CFG_IDX_ZONE3_ADDR: cfg_q.zone[2].base <= i_wr.data;
        `DMA_CFG_IDX_ZONE3_SIZE: cfg_q.zone[2].size <= i_wr.data;
        `DMA_CFG_IDX_ZONE4_ADDR: cfg_q.zone[3].base <= i_wr.data;
        `DMA_CFG_IDX_ZONE4_SIZE: cfg_q.zone[3].size <= i_wr.data;
        `DMA_CFG_IDX_ZONE_EN:    cfg_q.zone_en      <= i_wr.data[3:0];
        `DMA_CFG_IDX_SRC:        cfg_q.src          <= i_wr.data;
        `DMA_CFG_IDX_DST:        cfg_q.dst          <= i_wr.data;
        `DMA_CFG_IDX_DEPTH:      cfg_q.depth        <= i_wr.data;
        `DMA_CFG_IDX_AXI_CTRL:   axi_q.raw          <= i_wr.data;
        // ctrl, mask and clear slots handled elsewhere
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // commands
  // ----------------------------------------------------------------------
  // instruction buffer holds at most 4096 entries
  assign depth_ok = ~|cfg_q.depth[`DMA_CFG_DATA_W-1:`DMA_CFG_DEPTH_LIMIT_BIT];

  assign o_cmd.npu_start = ctrl_q[0];
  assign o_cmd.npu_stop  = ctrl_q[1];
  assign o_cmd.init_inst = ctrl_q[2] && depth_ok;
  assign o_init_fail     = ctrl_q[2] && !depth_ok;

  // soft reset only while the ctrl write is on the bus
  assign o_sys_reset_n = !(ctrl_wr && i_wr.data[3]);

  assign o_cfg  = cfg_q;
  assign o_axi  = axi_q;
  assign o_ctrl = ctrl_q;

  // relies on APB never writing ctrl on two back-to-back edges
  a_cmd_one_cycle: assert property (
    @(posedge pclk) disable iff (!preset_n)
    (ctrl_q[2:0] != 3'b000) |=> (ctrl_q[2:0] == 3'b000))
    else $error("dma_cfg_regfile: command bit held longer than one cycle");

endmodule

`default_nettype wire

// ==== verilog/dma_cfg_apb_decode.sv ====
`default_nettype none

`include "dma_cfg_consts.svh"

module dma_cfg_apb_decode (
  input  wire                              i_psel,
  input  wire                              i_penable,
  input  wire                              i_pwrite,
  input  wire [7:0]                        i_paddr,
  input  wire [`DMA_CFG_DATA_W-1:0]        i_pwdata,
  output dma_cfg_pkg::reg_wr_t             o_wr,
  output logic [`DMA_CFG_IDX_W-1:0]        o_rd_idx
);

  logic [`DMA_CFG_IDX_W-1:0] slot_idx;

  // word aligned, bits 1:0 ignored
  assign slot_idx = i_paddr[`DMA_CFG_IDX_W+1:2];

  // ----------------------------------------------------------------------
  // write strobe
  // ----------------------------------------------------------------------
  // access phase of a write, no wait states so one cycle wide
  assign o_wr.en   = i_psel && i_penable && i_pwrite;
  assign o_wr.idx  = slot_idx;
  assign o_wr.data = i_pwdata;

  // read mux index follows the address directly
  assign o_rd_idx = slot_idx;

  // an access phase is always part of a selected transfer
  always_comb begin
    a_penable_needs_psel: assert final (!(i_penable && !i_psel))
      else $error("dma_cfg_apb_decode: penable high without psel");
  end

endmodule

`default_nettype wire

// ==== verilog/dma_cfg_pkg.sv ====
`default_nettype none

`include "dma_cfg_consts.svh"

package dma_cfg_pkg;

  // one APB write, valid for the access phase only
  typedef struct packed {
    logic                       en;
    logic [`DMA_CFG_IDX_W-1:0]  idx;
    logic [`DMA_CFG_DATA_W-1:0] data;
  } reg_wr_t;

  // bit 10 is init fail, bits 9..0 come from the core
  typedef struct packed {
    logic                       init_fail;
    logic [`DMA_CFG_IRQ_W-2:0]  ext;
  } irq_vec_t;

  // ----------------------------------------------------------------------
  // AXI attribute word, msb first
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [3:0] awid;
    logic [1:0] awburst;
    logic       awlock;
    logic [2:0] awprot;
    logic [3:0] awcache;
    logic [3:0] wid;
    logic [3:0] arid;
    logic [1:0] arburst;
    logic       arlock;
    logic [2:0] arprot;
    logic [3:0] arcache;
  } axi_ctrl_fields_t;

  // raw for read-back, fields for the AXI master
  typedef union packed {
    logic [`DMA_CFG_DATA_W-1:0] raw;
    axi_ctrl_fields_t           fields;
  } axi_ctrl_u;

  typedef struct packed {
    logic [`DMA_CFG_DATA_W-1:0] base;
    logic [`DMA_CFG_DATA_W-1:0] size;
  } zone_cfg_t;

  // zone[0] is zone 1
  typedef struct packed {
    zone_cfg_t [3:0]            zone;
    logic [3:0]                 zone_en;
    logic [`DMA_CFG_DATA_W-1:0] src;
    logic [`DMA_CFG_DATA_W-1:0] dst;
    logic [`DMA_CFG_DATA_W-1:0] depth;
  } dma_cfg_t;

  // same bit order as ctrl[2:0]
  typedef struct packed {
    logic init_inst;
    logic npu_stop;
    logic npu_start;
  } dma_cmd_t;

endpackage

`default_nettype wire

// ==== include/dma_cfg_consts.svh ====
`ifndef DMA_CFG_CONSTS_SVH
`define DMA_CFG_CONSTS_SVH

// word and index widths
`define DMA_CFG_DATA_W 32
`define DMA_CFG_IDX_W 5
`define DMA_CFG_IRQ_W 11

// ----------------------------------------------------------------------
// register slots, paddr[6:2]
// ----------------------------------------------------------------------
`define DMA_CFG_IDX_CTRL 5'd0
`define DMA_CFG_IDX_IMR 5'd1
`define DMA_CFG_IDX_IRR 5'd2
`define DMA_CFG_IDX_ISR 5'd3
`define DMA_CFG_IDX_ZONE1_ADDR 5'd4
`define DMA_CFG_IDX_ZONE1_SIZE 5'd5
`define DMA_CFG_IDX_ZONE2_ADDR 5'd6
`define DMA_CFG_IDX_ZONE2_SIZE 5'd7
`define DMA_CFG_IDX_ZONE3_ADDR 5'd8
`define DMA_CFG_IDX_ZONE3_SIZE 5'd9
`define DMA_CFG_IDX_ZONE4_ADDR 5'd10
`define DMA_CFG_IDX_ZONE4_SIZE 5'd11
`define DMA_CFG_IDX_ZONE_EN 5'd12
`define DMA_CFG_IDX_SRC 5'd13
`define DMA_CFG_IDX_DST 5'd14
`define DMA_CFG_IDX_DEPTH 5'd15
`define DMA_CFG_IDX_AXI_CTRL 5'd18

// reset values
`define DMA_CFG_AXI_CTRL_RST 32'h048c_0123
`define DMA_CFG_IMR_RST 11'h7ff

// depth above 4095 fails init
`define DMA_CFG_DEPTH_LIMIT_BIT 12
`define DMA_CFG_IRQ_INIT_FAIL 10

`endif
